// File: src/zbuf_pkg.sv
`default_nettype none

package zbuf_pkg;

  // Bits per element, must be a multiple of 8
  parameter int unsigned ZBUF_WORD_W = 16;

  // Tile depth, elements in one Y or Z column
  parameter int unsigned ZBUF_ROWS = 4;

  // Tile width, elements in one Y or Z row
  parameter int unsigned ZBUF_COLS = 4;

  // Column bus carries one full column
  parameter int unsigned ZBUF_BUS_W = ZBUF_ROWS * ZBUF_WORD_W;

  // One strobe bit per byte of the column bus
  parameter int unsigned ZBUF_STRB_W = ZBUF_BUS_W / 8;

endpackage : zbuf_pkg

`default_nettype wire

// File: src/zbuf_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface zbuf_ctrl_if #(
  parameter int unsigned ROWS = zbuf_pkg::ZBUF_ROWS,
  parameter int unsigned COLS = zbuf_pkg::ZBUF_COLS
);

  // Index widths, sizes carry one more bit to hold the full count
  localparam int unsigned ROW_IW = (ROWS > 1) ? $clog2(ROWS) : 1;
  localparam int unsigned COL_IW = (COLS > 1) ? $clog2(COLS) : 1;

  // Strobes and levels from the engine
  logic              fill;
  logic              y_valid;
  logic              y_push;
  logic              z_ready;
  logic              first_load;

  // Active tile sizes
  logic [COL_IW:0]   y_width;
  logic [ROW_IW:0]   y_height;
  logic [COL_IW:0]   z_width;
  logic [ROW_IW:0]   z_height;

  // Status back to the engine
  logic              y_ready;
  logic              z_valid;
  logic              z_priority;
  logic              loaded;
  logic              y_pushed;
  logic              empty;

  modport ctl (
    output fill, y_valid, y_push, z_ready, first_load,
    output y_width, y_height, z_width, z_height,
    input  y_ready, z_valid, z_priority, loaded, y_pushed, empty
  );

  modport buffer (
    input  fill, y_valid, y_push, z_ready, first_load,
    input  y_width, y_height, z_width, z_height,
    output y_ready, z_valid, z_priority, loaded, y_pushed, empty
  );

endinterface : zbuf_ctrl_if

`default_nettype wire

// File: src/zbuf_storage.sv
`timescale 1ns/1ps
`default_nettype none

module zbuf_storage #(
  parameter int unsigned WORD_W = zbuf_pkg::ZBUF_WORD_W,
  parameter int unsigned ROWS   = zbuf_pkg::ZBUF_ROWS,
  parameter int unsigned COLS   = zbuf_pkg::ZBUF_COLS
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,
  input  logic                                  row_we_i,
  input  logic [((ROWS > 1) ? $clog2(ROWS) : 1)-1:0] row_waddr_i,
  input  logic [COLS-1:0][WORD_W-1:0]           row_wdata_i,
  input  logic                                  col_we_i,
  input  logic [((COLS > 1) ? $clog2(COLS) : 1)-1:0] col_waddr_i,
  input  logic [ROWS*WORD_W-1:0]                col_wdata_i,
  input  logic [((ROWS > 1) ? $clog2(ROWS) : 1)-1:0] row_raddr_i,
  input  logic [((COLS > 1) ? $clog2(COLS) : 1)-1:0] col_raddr_i,
  output logic [COLS-1:0][WORD_W-1:0]           row_rdata_o,
  output logic [ROWS*WORD_W-1:0]                col_rdata_o
);

  // Element array, first index is the row
  logic [ROWS-1:0][COLS-1:0][WORD_W-1:0] mem_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (clear_i) begin
      mem_q <= '0;
    end else begin
      if (row_we_i && col_we_i) begin
        $error("zbuf_storage: row and column write requested in the same cycle");
      end
      if (row_we_i) begin
        // Whole Z row from the compute array
        mem_q[row_waddr_i] <= row_wdata_i;
      end else if (col_we_i) begin
        // Y column spreads over all rows
        for (int unsigned r = 0; r < ROWS; r++) begin
          mem_q[r][col_waddr_i] <= col_wdata_i[r*WORD_W +: WORD_W];
        end
      end
    end
  end

  // Row read goes straight out
  assign row_rdata_o = mem_q[row_raddr_i];

  // Column read gathers one element per row
  always_comb begin
    col_rdata_o = '0;
    for (int unsigned r = 0; r < ROWS; r++) begin
      col_rdata_o[r*WORD_W +: WORD_W] = mem_q[r][col_raddr_i];
    end
  end

endmodule : zbuf_storage

`default_nettype wire

// File: src/zbuf_tile_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module zbuf_tile_buffer #(
  parameter int unsigned WORD_W = zbuf_pkg::ZBUF_WORD_W,
  parameter int unsigned ROWS   = zbuf_pkg::ZBUF_ROWS,
  parameter int unsigned COLS   = zbuf_pkg::ZBUF_COLS
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  zbuf_ctrl_if.buffer                       ctrl,
  input  logic [ROWS*WORD_W-1:0]            y_col_i,
  input  logic [COLS-1:0][WORD_W-1:0]       z_row_i,
  output logic [COLS-1:0][WORD_W-1:0]       y_row_o,
  output logic [ROWS*WORD_W-1:0]            z_col_o,
  output logic [ROWS*WORD_W/8-1:0]          z_strb_o
);

  localparam int unsigned BUS_W   = ROWS * WORD_W;
  localparam int unsigned BYTES_W = WORD_W / 8;
  localparam int unsigned ROW_IW  = (ROWS > 1) ? $clog2(ROWS) : 1;
  localparam int unsigned COL_IW  = (COLS > 1) ? $clog2(COLS) : 1;

  localparam logic [1:0] ST_EMPTY  = 2'd0;
  localparam logic [1:0] ST_LOADED = 2'd1;
  localparam logic [1:0] ST_PUSHED = 2'd2;

  logic [1:0]        state_q;
  logic [1:0]        state_d;

  // Fill and push walk rows, load and store walk columns
  logic [ROW_IW-1:0] fill_idx_q;
  logic [COL_IW-1:0] load_idx_q;
  logic [ROW_IW-1:0] push_idx_q;
  logic [COL_IW-1:0] store_idx_q;

  logic [ROW_IW:0]   z_h_last;
  logic [COL_IW:0]   y_w_last;
  logic [ROW_IW:0]   y_h_last;
  logic [COL_IW:0]   z_w_last;

  logic              fill_last;
  logic              load_last;
  logic              push_last;
  logic              store_last;
  logic              load_en;
  logic              store_en;
  logic              load_fire;
  logic              store_fire;

  // Last index of each configured size
  assign z_h_last = ctrl.z_height - 1'b1;
  assign y_w_last = ctrl.y_width - 1'b1;
  assign y_h_last = ctrl.y_height - 1'b1;
  assign z_w_last = ctrl.z_width - 1'b1;

  assign fill_last  = ({1'b0, fill_idx_q} == z_h_last);
  assign load_last  = ({1'b0, load_idx_q} == y_w_last);
  assign push_last  = ({1'b0, push_idx_q} == y_h_last);
  assign store_last = ({1'b0, store_idx_q} == z_w_last);

  // No new bias while a fill is ongoing or the old bias is still being pushed
  assign load_en    = (state_q == ST_EMPTY) && !ctrl.fill && (push_idx_q == '0);
  assign store_en   = (state_q == ST_PUSHED);
  assign load_fire  = load_en && ctrl.y_valid;
  assign store_fire = store_en && ctrl.z_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_EMPTY;
    end else if (clear_i) begin
      state_q <= ST_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_EMPTY: begin
        if (load_fire && load_last) begin
          state_d = ST_LOADED;
        end
        // A single row Z tile can complete here
        if (ctrl.fill && fill_last) begin
          state_d = ST_PUSHED;
        end
      end
      ST_LOADED: begin
        if (ctrl.y_push && push_last && !ctrl.fill) begin
          state_d = ST_EMPTY;
        end
        // Finished Z tile takes over from pushing
        if (ctrl.fill && fill_last) begin
          state_d = ST_PUSHED;
        end
      end
      ST_PUSHED: begin
        if (store_fire && store_last) begin
          state_d = ST_EMPTY;
        end
      end
      default: begin
        state_d = ST_EMPTY;
      end
    endcase
  end

  // Wrapping index counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_idx_q  <= '0;
      load_idx_q  <= '0;
      push_idx_q  <= '0;
      store_idx_q <= '0;
    end else if (clear_i) begin
      fill_idx_q  <= '0;
      load_idx_q  <= '0;
      push_idx_q  <= '0;
      store_idx_q <= '0;
    end else begin
      if (ctrl.fill) begin
        fill_idx_q <= fill_last ? '0 : fill_idx_q + 1'b1;
      end
      if (load_fire) begin
        load_idx_q <= load_last ? '0 : load_idx_q + 1'b1;
      end
      if (ctrl.y_push) begin
        push_idx_q <= push_last ? '0 : push_idx_q + 1'b1;
      end
      // Held under back-pressure
      if (store_fire) begin
        store_idx_q <= store_last ? '0 : store_idx_q + 1'b1;
      end
    end
  end

  assign ctrl.y_ready    = load_fire;
  assign ctrl.z_valid    = store_fire;
  assign ctrl.z_priority = store_en;
  assign ctrl.loaded     = ((state_q == ST_EMPTY) && load_fire && load_last) ||
                           (state_q == ST_LOADED);
  assign ctrl.y_pushed   = ctrl.y_push && push_last;
  assign ctrl.empty      = (store_fire && store_last) ||
                           ((state_q == ST_LOADED) && ctrl.y_push && push_last &&
                            ctrl.first_load);

  // Enable the bytes of every row inside the active height
  always_comb begin
    z_strb_o = '0;
    for (int unsigned r = 0; r < ROWS; r++) begin
      if (r < ctrl.z_height) begin
        z_strb_o[r*BYTES_W +: BYTES_W] = '1;
      end
    end
  end

  zbuf_storage #(
    .WORD_W (WORD_W),
    .ROWS   (ROWS),
    .COLS   (COLS)
  ) storage_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .row_we_i    (ctrl.fill),
    .row_waddr_i (fill_idx_q),
    .row_wdata_i (z_row_i),
    .col_we_i    (load_fire),
    .col_waddr_i (load_idx_q),
    .col_wdata_i (y_col_i[BUS_W-1:0]),
    .row_raddr_i (push_idx_q),
    .col_raddr_i (store_idx_q),
    .row_rdata_o (y_row_o),
    .col_rdata_o (z_col_o)
  );

  // Byte strobes need whole bytes in every element
  if (BYTES_W * 8 != WORD_W) begin : gen_width_check
    $error("zbuf_tile_buffer: WORD_W must be a multiple of 8");
  end

endmodule : zbuf_tile_buffer

`default_nettype wire

// File: src/zbuf_top.sv
`timescale 1ns/1ps
`default_nettype none

module zbuf_top #(
  parameter int unsigned WORD_W = zbuf_pkg::ZBUF_WORD_W,
  parameter int unsigned ROWS   = zbuf_pkg::ZBUF_ROWS,
  parameter int unsigned COLS   = zbuf_pkg::ZBUF_COLS
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  // Result rows from the compute array
  input  logic                                    fill_i,
  input  logic [COLS-1:0][WORD_W-1:0]             z_row_i,
  // Bias columns from memory
  input  logic                                    y_valid_i,
  output logic                                    y_ready_o,
  input  logic [ROWS*WORD_W-1:0]                  y_col_i,
  // Bias rows into the compute array
  input  logic                                    y_push_i,
  output logic [COLS-1:0][WORD_W-1:0]             y_row_o,
  // Result columns to memory
  input  logic                                    z_ready_i,
  output logic                                    z_valid_o,
  output logic [ROWS*WORD_W-1:0]                  z_data_o,
  output logic [ROWS*WORD_W/8-1:0]                z_strb_o,
  // Tile configuration
  input  logic                                    first_load_i,
  input  logic [((COLS > 1) ? $clog2(COLS) : 1):0] y_width_i,
  input  logic [((ROWS > 1) ? $clog2(ROWS) : 1):0] y_height_i,
  input  logic [((COLS > 1) ? $clog2(COLS) : 1):0] z_width_i,
  input  logic [((ROWS > 1) ? $clog2(ROWS) : 1):0] z_height_i,
  // Scheduler flags
  output logic                                    z_priority_o,
  output logic                                    loaded_o,
  output logic                                    y_pushed_o,
  output logic                                    empty_o
);

  zbuf_ctrl_if #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) ctrl_bus ();

  assign ctrl_bus.fill       = fill_i;
  assign ctrl_bus.y_valid    = y_valid_i;
  assign ctrl_bus.y_push     = y_push_i;
  assign ctrl_bus.z_ready    = z_ready_i;
  assign ctrl_bus.first_load = first_load_i;
  assign ctrl_bus.y_width    = y_width_i;
  assign ctrl_bus.y_height   = y_height_i;
  assign ctrl_bus.z_width    = z_width_i;
  assign ctrl_bus.z_height   = z_height_i;

  assign y_ready_o    = ctrl_bus.y_ready;
  assign z_valid_o    = ctrl_bus.z_valid;
  assign z_priority_o = ctrl_bus.z_priority;
  assign loaded_o     = ctrl_bus.loaded;
  assign y_pushed_o   = ctrl_bus.y_pushed;
  assign empty_o      = ctrl_bus.empty;

  zbuf_tile_buffer #(
    .WORD_W (WORD_W),
    .ROWS   (ROWS),
    .COLS   (COLS)
  ) tile_buffer_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .ctrl     (ctrl_bus.buffer),
    .y_col_i  (y_col_i),
    .z_row_i  (z_row_i),
    .y_row_o  (y_row_o),
    .z_col_o  (z_data_o),
    .z_strb_o (z_strb_o)
  );

endmodule : zbuf_top

`default_nettype wire

// File: testbench/zbuf_properties.sv
`timescale 1ns/1ps
`default_nettype none

module zbuf_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  input logic fill_i,
  input logic y_ready_i,
  input logic z_priority_i,
  input logic loaded_i,
  input logic empty_i
);

  // The pushed state is only entered by a fill
  a_pushed_after_fill : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(z_priority_i) |-> $past(fill_i))
    else $error("z_priority rose without a fill in the cycle before");

  // An accepted Y column never leads straight into the pushed state
  a_load_keeps_store_off : assert property (@(posedge clk_i) disable iff (!rst_ni)
    y_ready_i |=> !z_priority_i)
    else $error("z_priority high right after an accepted Y column");

  a_loaded_on_load : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(loaded_i) |-> y_ready_i)
    else $error("loaded rose without an accepted Y column");

  // Leaving the pushed state needs the last store or a clear
  a_store_exit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(z_priority_i) |-> $past(empty_i || clear_i))
    else $error("z_priority fell without empty or clear in the cycle before");

endmodule : zbuf_properties

bind zbuf_tile_buffer zbuf_properties props_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .clear_i      (clear_i),
  .fill_i       (ctrl.fill),
  .y_ready_i    (ctrl.y_ready),
  .z_priority_i (ctrl.z_priority),
  .loaded_i     (ctrl.loaded),
  .empty_i      (ctrl.empty)
);

`default_nettype wire

// File: testbench/zbuf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module zbuf_tb;
  import zbuf_pkg::*;

  localparam int unsigned WORD_W  = ZBUF_WORD_W;
  localparam int unsigned ROWS    = ZBUF_ROWS;
  localparam int unsigned COLS    = ZBUF_COLS;
  localparam int unsigned BUS_W   = ZBUF_BUS_W;
  localparam int unsigned STRB_W  = ZBUF_STRB_W;
  localparam int unsigned BYTES_W = WORD_W / 8;
  localparam int unsigned RSW     = ((ROWS > 1) ? $clog2(ROWS) : 1) + 1;
  localparam int unsigned CSW     = ((COLS > 1) ? $clog2(COLS) : 1) + 1;
  localparam int unsigned CHK_W   = (BUS_W > COLS * WORD_W) ? BUS_W : COLS * WORD_W;
  localparam int          STORE_TIMEOUT = 200;

  logic clk_i, rst_ni, clear, fill, y_valid, y_push, z_ready, first_load;
  logic y_ready, z_valid, z_priority, loaded, y_pushed, empty;
  logic [COLS-1:0][WORD_W-1:0] z_row;
  logic [COLS-1:0][WORD_W-1:0] y_row;
  logic [BUS_W-1:0]            y_col;
  logic [BUS_W-1:0]            z_data;
  logic [STRB_W-1:0]           z_strb;
  logic [CSW-1:0]              y_width, z_width;
  logic [RSW-1:0]              y_height, z_height;

  // Reference tile, first index is the row
  logic [WORD_W-1:0] model [ROWS][COLS];
  logic [31:0]       rng;
  int                yw, yh, zw, zh;
  int                errors;

  zbuf_top #(.WORD_W(WORD_W), .ROWS(ROWS), .COLS(COLS)) dut_i (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear),
    .fill_i(fill), .z_row_i(z_row), .y_valid_i(y_valid), .y_ready_o(y_ready),
    .y_col_i(y_col), .y_push_i(y_push), .y_row_o(y_row), .z_ready_i(z_ready),
    .z_valid_o(z_valid), .z_data_o(z_data), .z_strb_o(z_strb), .first_load_i(first_load),
    .y_width_i(y_width), .y_height_i(y_height), .z_width_i(z_width), .z_height_i(z_height),
    .z_priority_o(z_priority), .loaded_o(loaded), .y_pushed_o(y_pushed), .empty_o(empty)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Byte enables of the rows below the given height
  function automatic logic [STRB_W-1:0] strobe_for_height(input int h);
    logic [STRB_W-1:0] s;
    s = '0;
    for (int b = 0; b < h * BYTES_W; b++) s[b] = 1'b1;
    return s;
  endfunction

  task automatic stop_on_error();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [CHK_W-1:0] exp,
                       input logic [CHK_W-1:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic next_word(output logic [WORD_W-1:0] w);
    rng = xorshift32(rng);
    w = rng[WORD_W-1:0];
  endtask

  task automatic set_sizes(input int y_w, input int y_h, input int z_w, input int z_h);
    yw = y_w;
    yh = y_h;
    zw = z_w;
    zh = z_h;
    y_width  = CSW'(y_w);
    y_height = RSW'(y_h);
    z_width  = CSW'(z_w);
    z_height = RSW'(z_h);
  endtask

  task automatic apply_clear();
    @(negedge clk_i);
    {fill, y_valid, y_push, z_ready} = '0;
    clear = 1'b1;
    for (int r = 0; r < ROWS; r++)
      for (int c = 0; c < COLS; c++) model[r][c] = '0;
    @(negedge clk_i);
    clear = 1'b0;
  endtask

  // Loads columns 0 to n-1, each one accepted in its own cycle
  task automatic load_tile(input string name, input int n);
    logic [WORD_W-1:0] word;
    for (int c = 0; c < n; c++) begin
      @(negedge clk_i);
      y_valid = 1'b1;
      for (int r = 0; r < ROWS; r++) begin
        next_word(word);
        y_col[r*WORD_W +: WORD_W] = word;
        model[r][c] = word;
      end
      #1;
      check(name, CHK_W'(1'b1), CHK_W'(y_ready));
      check(name, CHK_W'(c == yw - 1), CHK_W'(loaded));
    end
  endtask

  task automatic push_tile(input string name, input logic expect_empty);
    logic [COLS-1:0][WORD_W-1:0] exp_row;
    for (int r = 0; r < yh; r++) begin
      @(negedge clk_i);
      y_valid = 1'b0;
      y_push  = 1'b1;
      #1;
      for (int c = 0; c < COLS; c++) exp_row[c] = model[r][c];
      check(name, CHK_W'(exp_row), CHK_W'(y_row));
      check(name, CHK_W'(r == yh - 1), CHK_W'(y_pushed));
      check(name, CHK_W'(expect_empty && (r == yh - 1)), CHK_W'(empty));
    end
    @(negedge clk_i);
    y_push = 1'b0;
  endtask

  task automatic fill_tile(input string name);
    logic [WORD_W-1:0] word;
    for (int r = 0; r < zh; r++) begin
      @(negedge clk_i);
      y_valid = 1'b0;
      fill    = 1'b1;
      for (int c = 0; c < COLS; c++) begin
        next_word(word);
        z_row[c]    = word;
        model[r][c] = word;
      end
      #1;
      check(name, CHK_W'(1'b0), CHK_W'(z_priority));
    end
    @(negedge clk_i);
    fill = 1'b0;
    #1;
    check(name, CHK_W'(1'b1), CHK_W'(z_priority));
    check(name, CHK_W'(1'b0), CHK_W'(loaded));
  endtask

  // Random back-pressure until zw columns are accepted
  task automatic store_tile(input string name, input logic offer_load);
    logic [BUS_W-1:0] exp_col, mask;
    int count, cycles;
    count  = 0;
    cycles = 0;
    mask   = '0;
    for (int r = 0; r < zh; r++) mask[r*WORD_W +: WORD_W] = '1;
    while (count < zw) begin
      if (cycles == STORE_TIMEOUT) begin
        $display("Timeout in %s: store columns were not all accepted", name);
        stop_on_error();
      end
      @(negedge clk_i);
      rng     = xorshift32(rng);
      z_ready = rng[0];
      y_valid = offer_load;
      #1;
      cycles++;
      check(name, CHK_W'(1'b1), CHK_W'(z_priority));
      check(name, CHK_W'(z_ready), CHK_W'(z_valid));
      check(name, CHK_W'(1'b0), CHK_W'(y_ready));
      check(name, CHK_W'(strobe_for_height(zh)), CHK_W'(z_strb));
      check(name, CHK_W'(z_ready && (count == zw - 1)), CHK_W'(empty));
      if (z_ready) begin
        for (int r = 0; r < ROWS; r++) exp_col[r*WORD_W +: WORD_W] = model[r][count];
        check(name, CHK_W'(exp_col & mask), CHK_W'(z_data & mask));
        count++;
      end
    end
    @(negedge clk_i);
    z_ready = 1'b0;
    y_valid = 1'b0;
    #1;
    check(name, CHK_W'(1'b0), CHK_W'(z_priority));
    check(name, CHK_W'(1'b0), CHK_W'(empty));
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    #1;
    check("reset", CHK_W'(5'b0), CHK_W'({z_valid, z_priority, loaded, y_pushed, empty}));
    check("reset", CHK_W'(1'b0), CHK_W'(y_ready));
    @(negedge clk_i);
    y_valid = 1'b1;
    #1;
    check("reset", CHK_W'(1'b1), CHK_W'(y_ready));
    apply_clear();
  endtask

  task automatic test_load_push();
    set_sizes(3, 3, COLS, ROWS);
    first_load = 1'b1;
    load_tile("load_push", yw);
    @(negedge clk_i);
    #1;
    check("load_push", CHK_W'(1'b0), CHK_W'(y_ready));
    check("load_push", CHK_W'(1'b1), CHK_W'(loaded));
    push_tile("load_push", 1'b1);
    #1;
    check("load_push", CHK_W'(1'b0), CHK_W'(loaded));
  endtask

  task automatic test_fill_store();
    @(negedge clk_i);
    set_sizes(COLS, ROWS, COLS, 3);
    fill_tile("fill_store");
    store_tile("fill_store", 1'b0);
  endtask

  task automatic test_strobe();
    for (int h = 1; h <= ROWS; h++) begin
      @(negedge clk_i);
      z_height = RSW'(h);
      #1;
      check("strobe", CHK_W'(strobe_for_height(h)), CHK_W'(z_strb));
    end
    @(negedge clk_i);
    z_height = RSW'(zh);
  endtask

  // A finished Z tile takes over a loaded bias tile
  task automatic test_preempt();
    first_load = 1'b0;
    set_sizes(COLS, ROWS, 2, 2);
    load_tile("preempt", yw);
    @(negedge clk_i);
    y_valid = 1'b0;
    #1;
    check("preempt", CHK_W'(1'b1), CHK_W'(loaded));
    fill_tile("preempt");
    store_tile("preempt", 1'b1);
    @(negedge clk_i);
    y_valid = 1'b1;
    #1;
    check("preempt", CHK_W'(1'b1), CHK_W'(y_ready));
    apply_clear();
  endtask

  // Without first_load the last push raises no empty pulse
  task automatic test_clear();
    set_sizes(COLS, ROWS, COLS, ROWS);
    first_load = 1'b0;
    apply_clear();
    load_tile("clear", 2);
    apply_clear();
    #1;
    check("clear", CHK_W'(3'b0), CHK_W'({loaded, z_priority, y_ready}));
    load_tile("clear", yw);
    push_tile("clear", 1'b0);
  endtask

  initial begin
    errors = 0;
    rng    = 32'h81e;
    rst_ni = 1'b0;
    {clear, fill, y_valid, y_push, z_ready, first_load} = '0;
    z_row = '0;
    y_col = '0;
    set_sizes(COLS, ROWS, COLS, ROWS);
    for (int r = 0; r < ROWS; r++)
      for (int c = 0; c < COLS; c++) model[r][c] = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset();
    test_load_push();
    test_fill_store();
    test_strobe();
    test_preempt();
    test_clear();
    @(negedge clk_i);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : zbuf_tb

`default_nettype wire

// File: zbuf.f
src/zbuf_pkg.sv
src/zbuf_ctrl_if.sv
src/zbuf_storage.sv
src/zbuf_tile_buffer.sv
src/zbuf_top.sv
testbench/zbuf_properties.sv
testbench/zbuf_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= zbuf_tb
FILELIST  ?= zbuf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
